//--- execute_stage.f
logic/exec_pkg.sv
logic/int_alu.sv
logic/serial_divider.sv
logic/uop_decoder.sv
logic/exec_unit.sv
logic/writeback_reg.sv
logic/execute_stage.sv
verif/execute_stage_sva.sv
verif/execute_stage_tb.sv

//--- logic/exec_pkg.sv
// Execute stage package: width typedefs, opcodes, operation codes, micro-op and writeback structs
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  unit_t;
    typedef logic [1:0]  div_op_t;
    typedef logic [2:0]  br_op_t;

    // RV32 major opcodes handled here
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU codes are {funct7[5], funct3} so OP decodes directly
    localparam alu_op_t ALU_ADD   = 4'b0000;
    localparam alu_op_t ALU_SLL   = 4'b0001;
    localparam alu_op_t ALU_SLT   = 4'b0010;
    localparam alu_op_t ALU_SLTU  = 4'b0011;
    localparam alu_op_t ALU_XOR   = 4'b0100;
    localparam alu_op_t ALU_SRL   = 4'b0101;
    localparam alu_op_t ALU_OR    = 4'b0110;
    localparam alu_op_t ALU_AND   = 4'b0111;
    localparam alu_op_t ALU_SUB   = 4'b1000;
    localparam alu_op_t ALU_SRA   = 4'b1101;
    localparam alu_op_t ALU_PASS2 = 4'b1111; // LUI

    localparam unit_t UNIT_NONE = 2'd0;
    localparam unit_t UNIT_ALU  = 2'd1;
    localparam unit_t UNIT_DIV  = 2'd2;
    localparam unit_t UNIT_LINK = 2'd3; // Writes pc+4

    // Low funct3 bits of DIV, DIVU, REM, REMU
    localparam div_op_t DIV_S = 2'd0;
    localparam div_op_t DIV_U = 2'd1;
    localparam div_op_t REM_S = 2'd2;
    localparam div_op_t REM_U = 2'd3;

    localparam br_op_t BR_NONE = 3'd0;
    localparam br_op_t BR_EQ   = 3'd1;
    localparam br_op_t BR_NE   = 3'd2;
    localparam br_op_t BR_LT   = 3'd3;
    localparam br_op_t BR_GE   = 3'd4;
    localparam br_op_t BR_LTU  = 3'd5;
    localparam br_op_t BR_GEU  = 3'd6;
    localparam br_op_t BR_JUMP = 3'd7;

    localparam int DIV_STEPS = 32;

    typedef struct packed {
        unit_t     unit;
        alu_op_t   alu_op;
        div_op_t   div_op;
        br_op_t    br_op;
        reg_addr_t rd;
        logic      wr_en;
        logic      illegal;
        word_t     op1;
        word_t     op2;         // Immediate for branches and jumps
        word_t     pc;
        word_t     target_base; // pc, or rs1 for JALR
        logic [2:0] cmp_flags;  // {lt, ltu, eq}
    } uop_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      valid;
    } wb_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

//--- logic/exec_unit.sv
// Execute unit: ALU, divider, branch resolution, result select, ready and forwarding
`timescale 1ns/1ps

module exec_unit (
    input  logic            clk_i,
    input  logic            rst_i,
    input  exec_pkg::uop_t  uop_i,
    output logic            ready_o,
    output exec_pkg::word_t fwd_value_o,
    output logic            fwd_valid_o,
    output logic            branch_taken_o,
    output exec_pkg::word_t branch_target_o,
    output logic            illegal_o,
    output exec_pkg::wb_t   wb_next_o
);

    exec_pkg::word_t alu_result, div_result, link_value, result;
    exec_pkg::word_t target_sum;
    logic            is_div, div_start, div_busy, div_done;

    int_alu i_int_alu (
        .op_i     (uop_i.alu_op),
        .a_i      (uop_i.op1),
        .b_i      (uop_i.op2),
        .result_o (alu_result)
    );

    assign is_div    = (uop_i.unit == exec_pkg::UNIT_DIV);
    assign div_start = is_div && !div_busy && !div_done; // Only from idle

    serial_divider i_serial_divider (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (uop_i.div_op),
        .dividend_i (uop_i.op1),
        .divisor_i  (uop_i.op2),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    assign link_value = uop_i.pc + 32'd4;

    always_comb begin
        case (uop_i.unit)
            exec_pkg::UNIT_DIV:  result = div_result;
            exec_pkg::UNIT_LINK: result = link_value;
            default:             result = alu_result;
        endcase
    end

    // Flags are {lt, ltu, eq}
    always_comb begin
        case (uop_i.br_op)
            exec_pkg::BR_EQ:   branch_taken_o = uop_i.cmp_flags[0];
            exec_pkg::BR_NE:   branch_taken_o = !uop_i.cmp_flags[0];
            exec_pkg::BR_LT:   branch_taken_o = uop_i.cmp_flags[2];
            exec_pkg::BR_GE:   branch_taken_o = !uop_i.cmp_flags[2];
            exec_pkg::BR_LTU:  branch_taken_o = uop_i.cmp_flags[1];
            exec_pkg::BR_GEU:  branch_taken_o = !uop_i.cmp_flags[1];
            exec_pkg::BR_JUMP: branch_taken_o = 1'b1;
            default:           branch_taken_o = 1'b0;
        endcase
    end

    assign target_sum      = uop_i.target_base + uop_i.op2;
    assign branch_target_o = {target_sum[31:1], 1'b0};

    assign ready_o     = !is_div || div_done; // Low from start through last run cycle
    assign fwd_value_o = result;
    assign fwd_valid_o = (uop_i.unit == exec_pkg::UNIT_ALU) ||
                         (uop_i.unit == exec_pkg::UNIT_LINK);
    assign illegal_o   = uop_i.illegal;

    assign wb_next_o.rd    = uop_i.rd;
    assign wb_next_o.value = result;
    assign wb_next_o.valid = uop_i.wr_en && (uop_i.rd != '0) && (!is_div || div_done);

endmodule

//--- logic/execute_stage.sv
// Execute stage top: decoder, execute unit and writeback register
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            instr_valid_i,
    input  exec_pkg::word_t instr_i,
    input  exec_pkg::word_t pc_i,
    input  exec_pkg::word_t rs1_val_i,
    input  exec_pkg::word_t rs2_val_i,
    output logic            ready_o,
    output exec_pkg::word_t fwd_value_o,
    output logic            fwd_valid_o,
    output logic            branch_taken_o,
    output exec_pkg::word_t branch_target_o,
    output logic            illegal_o,
    output exec_pkg::wb_t   wb_o
);

    exec_pkg::uop_t uop;
    exec_pkg::wb_t  wb_next;

    uop_decoder i_uop_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .uop_o         (uop)
    );

    exec_unit i_exec_unit (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .uop_i           (uop),
        .ready_o         (ready_o),
        .fwd_value_o     (fwd_value_o),
        .fwd_valid_o     (fwd_valid_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .illegal_o       (illegal_o),
        .wb_next_o       (wb_next)
    );

    writeback_reg i_writeback_reg (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wb_i  (wb_next),
        .wb_o  (wb_o)
    );

endmodule

//--- logic/int_alu.sv
// 32-bit integer ALU
`timescale 1ns/1ps

module int_alu (
    input  exec_pkg::alu_op_t op_i,
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    output exec_pkg::word_t   result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            exec_pkg::ALU_ADD:   result_o = a_i + b_i;
            exec_pkg::ALU_SUB:   result_o = a_i - b_i;
            exec_pkg::ALU_SLL:   result_o = a_i << shamt;
            exec_pkg::ALU_SLT:   result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            exec_pkg::ALU_SLTU:  result_o = {31'b0, a_i < b_i};
            exec_pkg::ALU_XOR:   result_o = a_i ^ b_i;
            exec_pkg::ALU_SRL:   result_o = a_i >> shamt;
            exec_pkg::ALU_SRA:   result_o = $signed(a_i) >>> shamt; // Sign fills from the left
            exec_pkg::ALU_OR:    result_o = a_i | b_i;
            exec_pkg::ALU_AND:   result_o = a_i & b_i;
            exec_pkg::ALU_PASS2: result_o = b_i;
            default:             result_o = '0;
        endcase
    end

endmodule

//--- logic/serial_divider.sv
// Restoring serial divider for DIV, DIVU, REM and REMU
`timescale 1ns/1ps

module serial_divider (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  exec_pkg::div_op_t op_i,
    input  exec_pkg::word_t   dividend_i,
    input  exec_pkg::word_t   divisor_i,
    output logic              busy_o,
    output logic              done_o,
    output exec_pkg::word_t   result_o
);

    exec_pkg::div_state_t state;
    logic [4:0] cnt;

    logic            is_signed;
    exec_pkg::word_t a_mag, b_mag;
    exec_pkg::word_t quo, rem, dvs;
    logic            neg_q, neg_r, div_zero, rem_sel;
    logic [32:0]     trial;
    exec_pkg::word_t q_fix, r_fix;

    assign is_signed = (op_i == exec_pkg::DIV_S) || (op_i == exec_pkg::REM_S);
    assign a_mag     = (is_signed && dividend_i[31]) ? -dividend_i : dividend_i;
    assign b_mag     = (is_signed && divisor_i[31])  ? -divisor_i  : divisor_i;

    // Shifted partial remainder minus divisor, bit 32 is the borrow
    assign trial = {rem, quo[31]} - {1'b0, dvs};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= exec_pkg::DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::DIV_IDLE: begin
                    if (start_i) begin
                        state <= exec_pkg::DIV_RUN;
                        cnt   <= 5'(exec_pkg::DIV_STEPS - 1);
                    end
                end
                exec_pkg::DIV_RUN: begin
                    cnt <= cnt - 5'd1;
                    if (cnt == 5'd0)
                        state <= exec_pkg::DIV_DONE;
                end
                default: state <= exec_pkg::DIV_IDLE; // Result taken in done cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == exec_pkg::DIV_IDLE && start_i) begin
            quo      <= a_mag;  // Dividend bits shift out as quotient bits shift in
            rem      <= '0;
            dvs      <= b_mag;
            neg_q    <= is_signed && (dividend_i[31] ^ divisor_i[31]);
            neg_r    <= is_signed && dividend_i[31];
            div_zero <= (divisor_i == '0);
            rem_sel  <= op_i[1];
        end else if (state == exec_pkg::DIV_RUN) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], quo[31]};
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // Overflow case needs no fix: 2^31 / 1 negated wraps back to the dividend, remainder 0
    assign q_fix = div_zero ? '1 : (neg_q ? -quo : quo);
    assign r_fix = neg_r ? -rem : rem; // Zero divisor leaves the dividend here

    assign result_o = rem_sel ? r_fix : q_fix;
    assign busy_o   = (state == exec_pkg::DIV_RUN);
    assign done_o   = (state == exec_pkg::DIV_DONE);

endmodule

//--- logic/uop_decoder.sv
// RV32IM instruction to micro-op decoder with operand select and compare flags
`timescale 1ns/1ps

module uop_decoder (
    input  logic            instr_valid_i,
    input  exec_pkg::word_t instr_i,
    input  exec_pkg::word_t pc_i,
    input  exec_pkg::word_t rs1_val_i,
    input  exec_pkg::word_t rs2_val_i,
    output exec_pkg::uop_t  uop_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    exec_pkg::word_t imm_i, imm_u, imm_b, imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        uop_o             = '0;
        uop_o.unit        = exec_pkg::UNIT_NONE;
        uop_o.br_op       = exec_pkg::BR_NONE;
        uop_o.rd          = instr_i[11:7];
        uop_o.op1         = rs1_val_i;
        uop_o.op2         = rs2_val_i;
        uop_o.pc          = pc_i;
        uop_o.target_base = pc_i;
        uop_o.div_op      = funct3[1:0];
        uop_o.cmp_flags   = {$signed(rs1_val_i) < $signed(rs2_val_i),
                             rs1_val_i < rs2_val_i,
                             rs1_val_i == rs2_val_i};
        case (opcode)
            exec_pkg::OPC_OP: begin
                if (funct7 == 7'b0000001 && funct3[2]) begin
                    uop_o.unit = exec_pkg::UNIT_DIV;
                end else if (funct7 == 7'b0000000 ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    uop_o.unit   = exec_pkg::UNIT_ALU;
                    uop_o.alu_op = {funct7[5], funct3};
                end else begin
                    uop_o.illegal = 1'b1; // MUL family is not in this stage
                end
            end
            exec_pkg::OPC_OP_IMM: begin
                uop_o.op2    = imm_i;
                uop_o.alu_op = {funct3 == 3'b101 && funct7[5], funct3};
                if ((funct3 == 3'b001 && funct7 != 7'b0000000) ||
                    (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000))
                    uop_o.illegal = 1'b1;
                else
                    uop_o.unit = exec_pkg::UNIT_ALU;
            end
            exec_pkg::OPC_LUI: begin
                uop_o.unit   = exec_pkg::UNIT_ALU;
                uop_o.alu_op = exec_pkg::ALU_PASS2;
                uop_o.op2    = imm_u;
            end
            exec_pkg::OPC_AUIPC: begin
                uop_o.unit   = exec_pkg::UNIT_ALU;
                uop_o.alu_op = exec_pkg::ALU_ADD;
                uop_o.op1    = imm_u;
                uop_o.op2    = pc_i;
            end
            exec_pkg::OPC_JAL: begin
                uop_o.unit  = exec_pkg::UNIT_LINK;
                uop_o.br_op = exec_pkg::BR_JUMP;
                uop_o.op2   = imm_j;
            end
            exec_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    uop_o.unit        = exec_pkg::UNIT_LINK;
                    uop_o.br_op       = exec_pkg::BR_JUMP;
                    uop_o.op2         = imm_i;
                    uop_o.target_base = rs1_val_i;
                end else begin
                    uop_o.illegal = 1'b1;
                end
            end
            exec_pkg::OPC_BRANCH: begin
                uop_o.op2 = imm_b;
                case (funct3)
                    3'b000:  uop_o.br_op = exec_pkg::BR_EQ;
                    3'b001:  uop_o.br_op = exec_pkg::BR_NE;
                    3'b100:  uop_o.br_op = exec_pkg::BR_LT;
                    3'b101:  uop_o.br_op = exec_pkg::BR_GE;
                    3'b110:  uop_o.br_op = exec_pkg::BR_LTU;
                    3'b111:  uop_o.br_op = exec_pkg::BR_GEU;
                    default: uop_o.illegal = 1'b1;
                endcase
            end
            default: uop_o.illegal = 1'b1;
        endcase
        uop_o.wr_en = (uop_o.unit != exec_pkg::UNIT_NONE);
        if (!instr_valid_i) begin // Bubble
            uop_o.unit    = exec_pkg::UNIT_NONE;
            uop_o.br_op   = exec_pkg::BR_NONE;
            uop_o.wr_en   = 1'b0;
            uop_o.illegal = 1'b0;
        end
    end

endmodule

//--- logic/writeback_reg.sv
// Writeback register between execute and writeback
`timescale 1ns/1ps

module writeback_reg (
    input  logic          clk_i,
    input  logic          rst_i,
    input  exec_pkg::wb_t wb_i,
    output exec_pkg::wb_t wb_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_i; // Valid lasts one cycle since the candidate drops or changes
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module execute_stage_tb \
        -f execute_stage.f -Mdir obj_dir -o execute_stage_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/execute_stage_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verif/execute_stage_sva.sv
// Bound assertions on ready, writeback and reset behavior of the execute stage
`timescale 1ns/1ps

module execute_stage_sva (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 ready_i,
    input exec_pkg::wb_t        wb_i,
    input exec_pkg::div_state_t div_state_i
);

    logic [7:0] low_cycles; // Consecutive cycles with ready low

    always_ff @(posedge clk_i) begin
        if (rst_i || ready_i) begin
            low_cycles <= '0;
        end else begin
            low_cycles <= low_cycles + 8'd1;
        end
    end

    // Outside a run, ready only drops in the cycle that starts the divider
    ready_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        (div_state_i != exec_pkg::DIV_RUN && !ready_i) |=> div_state_i == exec_pkg::DIV_RUN)
        else $error("ready_o low while the divider stays idle");

    no_wb_to_x0: assert property (@(posedge clk_i) wb_i.valid |-> wb_i.rd != 5'd0)
        else $error("Writeback valid for register x0");

    wb_quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !wb_i.valid)
        else $error("Writeback valid during reset");

    // Start cycle plus 32 run cycles stays under this bound
    ready_returns: assert property (@(posedge clk_i) disable iff (rst_i)
        !ready_i |-> low_cycles < 8'd34)
        else $error("ready_o stayed low for more than 34 cycles");

endmodule

bind execute_stage execute_stage_sva i_execute_stage_sva (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ready_i     (ready_o),
    .wb_i        (wb_o),
    .div_state_i (i_exec_unit.i_serial_divider.state)
);

//--- verif/execute_stage_tb.sv
// Execute stage testbench: stimulus table, reference model, clock, reset, timeout and summary
`timescale 1ns/1ps

module execute_stage_tb;

    typedef struct packed {
        logic            valid;
        exec_pkg::word_t instr;
        exec_pkg::word_t pc;
        exec_pkg::word_t rs1;
        exec_pkg::word_t rs2;
        exec_pkg::word_t value;   // Expected forward and writeback value
        logic [4:0]      rd;      // Zero means no writeback expected
        logic            fwd;
        logic            slow;    // Divide, ready drops
        logic            taken;
        exec_pkg::word_t target;
        logic            illegal;
    } row_t;

    logic            clk_i, rst_i, instr_valid_i;
    exec_pkg::word_t instr_i, pc_i, rs1_val_i, rs2_val_i;
    logic            ready_o, fwd_valid_o, branch_taken_o, illegal_o;
    exec_pkg::word_t fwd_value_o, branch_target_o;
    exec_pkg::wb_t   wb_o;

    row_t   rows[$];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit  = 100000; // Set from the table size once it is built
    integer seed   = 32'h1ddc;

    execute_stage i_execute_stage (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_val_i       (rs1_val_i),
        .rs2_val_i       (rs2_val_i),
        .ready_o         (ready_o),
        .fwd_value_o     (fwd_value_o),
        .fwd_valid_o     (fwd_valid_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .illegal_o       (illegal_o),
        .wb_o            (wb_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare(input string what, input int row, input exec_pkg::word_t got,
                           input exec_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
        end
    endtask

    // Instruction encoders, register fields rs1 = x1 and rs2 = x2
    function automatic exec_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic exec_pkg::word_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic exec_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic exec_pkg::word_t b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic exec_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // RV32IM result of an OP instruction
    function automatic exec_pkg::word_t ref_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                                  input exec_pkg::word_t a,
                                                  input exec_pkg::word_t b);
        exec_pkg::word_t r;
        if (f7 == 7'b0000001) begin
            if (b == 32'd0) begin
                r = f3[1] ? a : 32'hffff_ffff;
            end else if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                r = f3[1] ? 32'd0 : a; // Signed overflow
            end else begin
                case (f3[1:0])
                    2'd0:    r = $signed(a) / $signed(b);
                    2'd1:    r = a / b;
                    2'd2:    r = $signed(a) % $signed(b);
                    default: r = a % b;
                endcase
            end
        end else begin
            case (f3)
                3'd0:    r = f7[5] ? a - b : a + b;
                3'd1:    r = a << b[4:0];
                3'd2:    r = {31'd0, $signed(a) < $signed(b)};
                3'd3:    r = {31'd0, a < b};
                3'd4:    r = a ^ b;
                3'd5: begin
                    if (f7[5])
                        r = $signed(a) >>> b[4:0];
                    else
                        r = a >> b[4:0];
                end
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input exec_pkg::word_t a,
                                        input exec_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic alu_row(input exec_pkg::word_t instr, pc, a, b, value);
        rows.push_back(row_t'{valid: 1'b1, instr: instr, pc: pc, rs1: a, rs2: b,
                              value: value, rd: instr[11:7], fwd: 1'b1, slow: 1'b0,
                              taken: 1'b0, target: 32'd0, illegal: 1'b0});
    endtask

    task automatic div_row(input exec_pkg::word_t instr, a, b, value);
        rows.push_back(row_t'{valid: 1'b1, instr: instr, pc: 32'd0, rs1: a, rs2: b,
                              value: value, rd: instr[11:7], fwd: 1'b0, slow: 1'b1,
                              taken: 1'b0, target: 32'd0, illegal: 1'b0});
    endtask

    task automatic jump_row(input exec_pkg::word_t instr, pc, a, target);
        rows.push_back(row_t'{valid: 1'b1, instr: instr, pc: pc, rs1: a, rs2: 32'd0,
                              value: pc + 32'd4, rd: instr[11:7], fwd: 1'b1, slow: 1'b0,
                              taken: 1'b1, target: target, illegal: 1'b0});
    endtask

    task automatic branch_row(input exec_pkg::word_t instr, pc, a, b, input logic taken,
                              input exec_pkg::word_t target);
        rows.push_back(row_t'{valid: 1'b1, instr: instr, pc: pc, rs1: a, rs2: b,
                              value: 32'd0, rd: 5'd0, fwd: 1'b0, slow: 1'b0,
                              taken: taken, target: target, illegal: 1'b0});
    endtask

    // Bubbles and illegal encodings, nothing may come out
    task automatic quiet_row(input logic valid, input exec_pkg::word_t instr,
                             input logic illegal);
        rows.push_back(row_t'{valid: valid, instr: instr, pc: 32'd0, rs1: 32'd5,
                              rs2: 32'd6, value: 32'd0, rd: 5'd0, fwd: 1'b0, slow: 1'b0,
                              taken: 1'b0, target: 32'd0, illegal: illegal});
    endtask

    task automatic run_row(input int n);
        row_t r;
        r = rows[n];
        @(posedge clk_i);
        instr_valid_i <= r.valid;
        instr_i       <= r.instr;
        pc_i          <= r.pc;
        rs1_val_i     <= r.rs1;
        rs2_val_i     <= r.rs2;
        @(negedge clk_i);
        compare("illegal_o", n, 32'(illegal_o), 32'(r.illegal));
        compare("branch_taken_o", n, 32'(branch_taken_o), 32'(r.taken));
        if (r.taken)
            compare("branch_target_o", n, branch_target_o, r.target);
        compare("ready_o", n, 32'(ready_o), 32'(!r.slow));
        compare("fwd_valid_o", n, 32'(fwd_valid_o), 32'(r.fwd));
        if (r.fwd)
            compare("fwd_value_o", n, fwd_value_o, r.value);
        while (!ready_o) begin // Inputs held while the divider runs
            @(negedge clk_i);
            compare("fwd_valid_o", n, 32'(fwd_valid_o), 32'(r.fwd));
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0; // Drain the result
        @(negedge clk_i);
        compare("wb_o.valid", n, 32'(wb_o.valid), 32'(r.rd != 5'd0));
        if (r.rd != 5'd0) begin
            compare("wb_o.rd", n, 32'(wb_o.rd), 32'(r.rd));
            compare("wb_o.value", n, wb_o.value, r.value);
        end
    endtask

    initial begin
        logic [2:0]      br_f3 [6];
        exec_pkg::word_t pair_a [4];
        exec_pkg::word_t pair_b [4];
        exec_pkg::word_t a, b;
        logic [6:0]      f7;
        logic [2:0]      f3;
        rst_i         = 1'b1;
        instr_valid_i = 1'b1; // A valid write during reset must not reach wb_o
        instr_i       = i_type(12'h001, 3'b000, 5'd3, 7'b0010011);
        pc_i          = '0;
        rs1_val_i     = '0;
        rs2_val_i     = '0;
        br_f3         = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pair_a        = '{32'd7, 32'd3, 32'd9, 32'hffff_fffe}; // Equal, less, greater, sign
        pair_b        = '{32'd7, 32'd9, 32'd3, 32'd3};

        alu_row(i_type(12'hfff, 3'b000, 5'd5, 7'b0010011), 32'd0, 32'd100, 32'd0, 32'd99);
        alu_row(i_type(12'h01f, 3'b001, 5'd6, 7'b0010011), 32'd0, 32'd1, 32'd0, 32'h8000_0000);
        alu_row(i_type(12'h41f, 3'b101, 5'd7, 7'b0010011), 32'd0, 32'h8000_0000, 32'd0, '1);
        alu_row(i_type(12'h01f, 3'b101, 5'd8, 7'b0010011), 32'd0, 32'h8000_0000, 32'd0, 32'd1);
        alu_row(r_type(7'h00, 3'b010, 5'd9), 32'd0, 32'hffff_fffb, 32'd3, 32'd1);
        alu_row(r_type(7'h00, 3'b011, 5'd10), 32'd0, 32'hffff_fffb, 32'd3, 32'd0);
        alu_row(i_type(12'h000, 3'b010, 5'd11, 7'b0010011), 32'd0, '1, 32'd0, 32'd1);
        alu_row(i_type(12'hfff, 3'b011, 5'd12, 7'b0010011), 32'd0, 32'd5, 32'd0, 32'd1);
        alu_row(r_type(7'h20, 3'b000, 5'd13), 32'd0, 32'd5, 32'd7, 32'hffff_fffe);
        alu_row(r_type(7'h20, 3'b101, 5'd14), 32'd0, 32'hf000_0000, 32'd4, 32'hff00_0000);
        alu_row(i_type(12'hfff, 3'b100, 5'd15, 7'b0010011), 32'd0, 32'h0f0f_0f0f, 32'd0,
                32'hf0f0_f0f0);
        alu_row(r_type(7'h00, 3'b001, 5'd18), 32'd0, 32'd3, 32'h3f, 32'h8000_0000);
        alu_row(u_type(20'hdead5, 5'd16, 7'b0110111), 32'd0, 32'd0, 32'd0, 32'hdead_5000);
        alu_row(u_type(20'h00001, 5'd17, 7'b0010111), 32'h1000, 32'd0, 32'd0, 32'h2000);
        alu_row(i_type(12'h001, 3'b000, 5'd0, 7'b0010011), 32'd0, 32'd5, 32'd0, 32'd6);

        jump_row(j_type(21'h000800, 5'd1), 32'h3000, 32'd0, 32'h3800);
        jump_row(i_type(12'h002, 3'b000, 5'd1, 7'b1100111), 32'h3000, 32'h4001, 32'h4002);

        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 4; p++) begin
                branch_row(b_type(p[0] ? 13'h1ff0 : 13'h0010, br_f3[i]), 32'h2000, pair_a[p],
                           pair_b[p], branch_ref(br_f3[i], pair_a[p], pair_b[p]),
                           p[0] ? 32'h1ff0 : 32'h2010);
            end
        end

        div_row(r_type(7'h01, 3'b100, 5'd20), 32'h8000_0000, '1, 32'h8000_0000);
        div_row(r_type(7'h01, 3'b110, 5'd20), 32'h8000_0000, '1, 32'd0);
        div_row(r_type(7'h01, 3'b100, 5'd21), 32'd7, 32'd0, '1);
        div_row(r_type(7'h01, 3'b101, 5'd21), 32'd7, 32'd0, '1);
        div_row(r_type(7'h01, 3'b110, 5'd22), 32'd7, 32'd0, 32'd7);
        div_row(r_type(7'h01, 3'b111, 5'd22), 32'd7, 32'd0, 32'd7);
        div_row(r_type(7'h01, 3'b100, 5'd23), 32'hffff_fff9, 32'd2, 32'hffff_fffd);
        div_row(r_type(7'h01, 3'b110, 5'd23), 32'hffff_fff9, 32'd2, '1);
        div_row(r_type(7'h01, 3'b100, 5'd0), 32'd9, 32'd3, 32'd3);

        quiet_row(1'b0, i_type(12'h001, 3'b000, 5'd3, 7'b0010011), 1'b0);
        quiet_row(1'b1, i_type(12'h000, 3'b010, 5'd3, 7'b0000011), 1'b1); // Load
        quiet_row(1'b1, r_type(7'h01, 3'b000, 5'd3), 1'b1);                // MUL

        for (int k = 0; k < 12; k++) begin
            a  = $random(seed);
            b  = $random(seed);
            f3 = {1'b1, 2'(k)};
            if (k % 3 == 2)
                b = b >> 28; // Small divisors
            div_row(r_type(7'h01, f3, 5'd24), a, b, ref_rtype(7'h01, f3, a, b));
        end
        for (int k = 0; k < 8; k++) begin
            a  = $random(seed);
            b  = $random(seed);
            f3 = 3'(k);
            f7 = (k == 0 || k == 5) ? 7'h20 : 7'h00;
            alu_row(r_type(f7, f3, 5'd25), 32'd0, a, b, ref_rtype(f7, f3, a, b));
        end
        limit = rows.size() * 40 + 100;

        repeat (16) @(posedge clk_i);
        rst_i         <= 1'b0;
        instr_valid_i <= 1'b0;
        foreach (rows[n])
            run_row(n);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
